//--- Makefile
# Verilator build and run for the AHB to APB bridge testbench

VERILATOR ?= verilator
TOP       ?= ahbApbBridgeTb
FILELIST  ?= ahbApbBridge.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation finished: PASS
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- ahbApbBridge.f
hw/bridgePkg.sv
hw/ahbSlaveInterface.sv
hw/apbFsmController.sv
hw/apbPortMux.sv
hw/ahbApbBridge.sv
verification/apbPeripheralModel.sv
verification/ahbApbBridgeTb.sv

//--- hw/ahbApbBridge.sv
// ====================================================================
// AHB-Lite to APB bridge top: slave interface, APB sequencer
// and peripheral port mux
// ====================================================================

module ahbApbBridge #(
	parameter bridgePkg::addrT PeriphBase = 32'h8000_0000,
	parameter int RegionShift = 26
) (
	input  logic              Hclk,
	input  logic              Hresetn,
	input  bridgePkg::addrT   Haddr,
	input  bridgePkg::dataT   Hwdata,
	input  logic              Hwrite,
	input  bridgePkg::htransT Htrans,
	input  logic              Hreadyin,
	output bridgePkg::dataT   Hrdata,
	output logic              Hreadyout,
	output logic [1:0]        Hresp,
	output logic              Psel0,
	output logic              Psel1,
	output logic              Psel2,
	output logic              Penable,
	output logic              Pwrite,
	output bridgePkg::addrT   Paddr,
	output bridgePkg::dataT   Pwdata,
	input  bridgePkg::dataT   Prdata0,
	input  bridgePkg::dataT   Prdata1,
	input  bridgePkg::dataT   Prdata2
);

	bridgePkg::ahbPipeT pipe;
	bridgePkg::apbBusT  apbBus;

	assign Hresp = 2'b00;  // always OKAY

	ahbSlaveInterface #(
		.PeriphBase (PeriphBase),
		.RegionShift(RegionShift)
	) ahbSlaveInterface_inst (
		.Hclk    (Hclk),
		.Hresetn (Hresetn),
		.Haddr   (Haddr),
		.Hwdata  (Hwdata),
		.Hwrite  (Hwrite),
		.Htrans  (Htrans),
		.Hreadyin(Hreadyin),
		.pipe    (pipe)
	);

	apbFsmController apbFsmController_inst (
		.Hclk     (Hclk),
		.Hresetn  (Hresetn),
		.pipe     (pipe),
		.Hwrite   (Hwrite),
		.Hwdata   (Hwdata),
		.apbBus   (apbBus),
		.Hreadyout(Hreadyout)
	);

	apbPortMux apbPortMux_inst (
		.Hclk   (Hclk),
		.Hresetn(Hresetn),
		.apbBus (apbBus),
		.Prdata0(Prdata0),
		.Prdata1(Prdata1),
		.Prdata2(Prdata2),
		.Psel0  (Psel0),
		.Psel1  (Psel1),
		.Psel2  (Psel2),
		.Penable(Penable),
		.Pwrite (Pwrite),
		.Paddr  (Paddr),
		.Pwdata (Pwdata),
		.Hrdata (Hrdata)
	);

endmodule

//--- hw/ahbSlaveInterface.sv
// ====================================================================
// AHB slave side of the bridge: transfer qualification, window
// decode to a one-hot select, two-deep address/data pipeline
// ====================================================================

module ahbSlaveInterface #(
	parameter bridgePkg::addrT PeriphBase = 32'h8000_0000,
	parameter int RegionShift = 26
) (
	input  logic               Hclk,
	input  logic               Hresetn,
	input  bridgePkg::addrT    Haddr,
	input  bridgePkg::dataT    Hwdata,
	input  logic               Hwrite,
	input  bridgePkg::htransT  Htrans,
	input  logic               Hreadyin,
	output bridgePkg::ahbPipeT pipe
);

	bridgePkg::addrT offset;
	bridgePkg::addrT regionIdx;
	logic            inWindow;
	logic            activeTrans;
	logic            valid;
	bridgePkg::selT  tempSel;
	bridgePkg::addrT haddr1;
	bridgePkg::addrT haddr2;
	bridgePkg::dataT hwdata1;
	bridgePkg::dataT hwdata2;
	logic            hwriteReg;

	assign offset = Haddr - PeriphBase;
	assign regionIdx = offset >> RegionShift;  // peripheral index inside the window
	assign inWindow = (Haddr >= PeriphBase) && (regionIdx < 3);

	assign activeTrans = (Htrans == bridgePkg::transNonseq) || (Htrans == bridgePkg::transSeq);
	assign valid = activeTrans && Hreadyin && inWindow;

	always_comb
	begin
		tempSel = '0;
		if (regionIdx < 3)
			tempSel[regionIdx[1:0]] = 1'b1;
	end

	// free-running delay line, stage n holds the bus value n edges back
	always_ff @(posedge Hclk)
	begin
		haddr1 <= Haddr;
		haddr2 <= haddr1;
		hwdata1 <= Hwdata;
		hwdata2 <= hwdata1;
	end

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			hwriteReg <= 1'b0;
		else if (valid)
			hwriteReg <= Hwrite;  // only accepted address phases
	end

	assign pipe = '{
		valid:     valid,
		haddr:     Haddr,
		haddr1:    haddr1,
		haddr2:    haddr2,
		hwdata1:   hwdata1,
		hwdata2:   hwdata2,
		hwriteReg: hwriteReg,
		tempSel:   tempSel
	};

	selOneHot: assert property (@(posedge Hclk) disable iff (!Hresetn)
		valid |-> $onehot(tempSel));

endmodule

//--- hw/apbFsmController.sv
// ====================================================================
// APB sequencer: eight-state controller with registered APB bus
// and Hreadyout, including the pipelined write states
// ====================================================================

module apbFsmController (
	input  logic               Hclk,
	input  logic               Hresetn,
	input  bridgePkg::ahbPipeT pipe,
	input  logic               Hwrite,
	input  bridgePkg::dataT    Hwdata,
	output bridgePkg::apbBusT  apbBus,
	output logic               Hreadyout
);

	bridgePkg::apbStateE state;
	bridgePkg::apbStateE stateNext;
	bridgePkg::apbBusT   busNext;
	logic                readyNext;
	logic                startRead;
	logic                startWrite;
	bridgePkg::selT      sel1;  // select of haddr1
	bridgePkg::selT      sel2;  // select of haddr2

	assign startRead = pipe.valid && !Hwrite;
	assign startWrite = pipe.valid && Hwrite;

	always_ff @(posedge Hclk)
	begin
		sel1 <= pipe.tempSel;
		sel2 <= sel1;
	end

	always_comb
	begin
		stateNext = state;
		case (state)
			bridgePkg::stIdle, bridgePkg::stRenable, bridgePkg::stWenable:
			begin
				if (startWrite)
					stateNext = bridgePkg::stWwait;
				else if (startRead)
					stateNext = bridgePkg::stRead;
				else
					stateNext = bridgePkg::stIdle;
			end
			bridgePkg::stWwait:
			begin
				if (pipe.valid)
					stateNext = bridgePkg::stWriteP;  // next address already taken
				else
					stateNext = bridgePkg::stWrite;
			end
			bridgePkg::stRead:
				stateNext = bridgePkg::stRenable;
			bridgePkg::stWrite:
			begin
				if (pipe.valid)
					stateNext = bridgePkg::stWenableP;
				else
					stateNext = bridgePkg::stWenable;
			end
			bridgePkg::stWriteP:
				stateNext = bridgePkg::stWenableP;
			bridgePkg::stWenableP:
			begin
				if (!pipe.hwriteReg)
					stateNext = bridgePkg::stRead;  // queued read
				else if (pipe.valid)
					stateNext = bridgePkg::stWriteP;
				else
					stateNext = bridgePkg::stWrite;
			end
		endcase
	end

	// next APB bus and Hreadyout for the clock edge
	always_comb
	begin
		busNext = apbBus;
		readyNext = Hreadyout;
		case (state)
			bridgePkg::stIdle, bridgePkg::stRenable, bridgePkg::stWenable:
			begin
				busNext.penable = 1'b0;
				readyNext = 1'b1;
				if (startRead)
				begin
					busNext.paddr = pipe.haddr;
					busNext.pwrite = 1'b0;
					busNext.pselx = pipe.tempSel;
					readyNext = 1'b0;
				end
				else
					busNext.pselx = '0;
			end
			bridgePkg::stWwait:
			begin
				// write address from last cycle with the live data phase
				busNext.paddr = pipe.haddr1;
				busNext.pwdata = Hwdata;
				busNext.pwrite = 1'b1;
				busNext.pselx = sel1;
				busNext.penable = 1'b0;
				readyNext = 1'b0;
			end
			bridgePkg::stRead, bridgePkg::stWrite:
			begin
				busNext.penable = 1'b1;
				readyNext = 1'b1;
			end
			bridgePkg::stWriteP:
			begin
				busNext.penable = 1'b1;
				readyNext = pipe.hwriteReg;  // a queued read keeps the master waiting
			end
			bridgePkg::stWenableP:
			begin
				busNext.paddr = pipe.haddr2;
				busNext.pwdata = pipe.hwdata1;
				busNext.pwrite = pipe.hwriteReg;
				busNext.pselx = sel2;
				busNext.penable = 1'b0;
				readyNext = 1'b0;
			end
		endcase
	end

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			state <= bridgePkg::stIdle;
			apbBus.pselx <= '0;
			apbBus.penable <= 1'b0;
			apbBus.pwrite <= 1'b0;
			Hreadyout <= 1'b0;
		end
		else
		begin
			state <= stateNext;
			apbBus <= busNext;
			Hreadyout <= readyNext;
		end
	end

	// setup state holds a setup phase on the bus and hands over to its enable state
	readSetupToEnable: assert property (@(posedge Hclk) disable iff (!Hresetn)
		state == bridgePkg::stRead |=> state == bridgePkg::stRenable && apbBus.penable
		&& $past(|apbBus.pselx && !apbBus.penable && !apbBus.pwrite));

	writeSetupToEnable: assert property (@(posedge Hclk) disable iff (!Hresetn)
		state inside {bridgePkg::stWrite, bridgePkg::stWriteP}
		|=> state inside {bridgePkg::stWenable, bridgePkg::stWenableP} && apbBus.penable
		&& $past(|apbBus.pselx && !apbBus.penable && apbBus.pwrite));

	readyInRenable: assert property (@(posedge Hclk) disable iff (!Hresetn)
		state == bridgePkg::stRenable |-> Hreadyout);

	// write enable carries the word the AHB side sampled two edges back
	writeDataAligned: assert property (@(posedge Hclk) disable iff (!Hresetn)
		apbBus.penable && apbBus.pwrite |-> apbBus.pwdata == pipe.hwdata2);

endmodule

//--- hw/apbPortMux.sv
// ====================================================================
// APB port side: per-peripheral selects, shared APB lines,
// read data mux registered onto Hrdata, APB phase checks
// ====================================================================

module apbPortMux (
	input  logic              Hclk,
	input  logic              Hresetn,
	input  bridgePkg::apbBusT apbBus,
	input  bridgePkg::dataT   Prdata0,
	input  bridgePkg::dataT   Prdata1,
	input  bridgePkg::dataT   Prdata2,
	output logic              Psel0,
	output logic              Psel1,
	output logic              Psel2,
	output logic              Penable,
	output logic              Pwrite,
	output bridgePkg::addrT   Paddr,
	output bridgePkg::dataT   Pwdata,
	output bridgePkg::dataT   Hrdata
);

	bridgePkg::dataT readData;

	assign {Psel2, Psel1, Psel0} = apbBus.pselx;
	assign Penable = apbBus.penable;
	assign Pwrite = apbBus.pwrite;
	assign Paddr = apbBus.paddr;
	assign Pwdata = apbBus.pwdata;

	always_comb
	begin
		case (apbBus.pselx)
			3'b001: readData = Prdata0;
			3'b010: readData = Prdata1;
			3'b100: readData = Prdata2;
			default: readData = '0;
		endcase
	end

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
			Hrdata <= '0;
		else if (apbBus.penable && !apbBus.pwrite)
			Hrdata <= readData;  // end of read enable
	end

	enableOneSel: assert property (@(posedge Hclk) disable iff (!Hresetn)
		apbBus.penable |-> $onehot(apbBus.pselx));

	// setup is always followed by enable on the same address
	setupStable: assert property (@(posedge Hclk) disable iff (!Hresetn)
		(|apbBus.pselx && !apbBus.penable) |=> apbBus.penable && $stable(apbBus.paddr));

endmodule

//--- hw/bridgePkg.sv
// ====================================================================
// bridge package: address/data/select types, Htrans codes,
// APB controller states, AHB pipeline and APB bus structs
// ====================================================================

package bridgePkg;

	typedef logic [31:0] addrT;
	typedef logic [31:0] dataT;
	typedef logic [2:0]  selT;   // one-hot, bit n selects peripheral n
	typedef logic [1:0]  htransT;

	localparam htransT transIdle   = 2'b00;
	localparam htransT transBusy   = 2'b01;
	localparam htransT transNonseq = 2'b10;
	localparam htransT transSeq    = 2'b11;

	typedef enum logic [2:0] {
		stIdle     = 3'd0,
		stWwait    = 3'd1,
		stRead     = 3'd2,
		stWrite    = 3'd3,
		stWriteP   = 3'd4,
		stRenable  = 3'd5,
		stWenable  = 3'd6,
		stWenableP = 3'd7
	} apbStateE;

	typedef struct packed {
		logic valid;      // eligible transfer in the current address phase
		addrT haddr;
		addrT haddr1;
		addrT haddr2;
		dataT hwdata1;
		dataT hwdata2;
		logic hwriteReg;  // direction of the last accepted transfer
		selT  tempSel;
	} ahbPipeT;

	typedef struct packed {
		addrT paddr;
		dataT pwdata;
		logic pwrite;
		logic penable;
		selT  pselx;
	} apbBusT;

endpackage

//--- verification/ahbApbBridgeTb.sv
// ====================================================================
// AHB to APB bridge testbench with AHB master tasks, LFSR,
// reference memory, APB scoreboard assertions and watchdog
// ====================================================================

module ahbApbBridgeTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam bridgePkg::addrT PeriphBase = 32'h8000_0000;
	localparam int RegionShift = 26;
	localparam int NumSingle = 6;
	localparam int NumBlind = 3;  // random reads that mostly hit unwritten words
	localparam int NumBurst = 8;
	localparam int PlannedXfers = 2 * NumSingle + NumBlind + 2 * NumBurst;
	localparam int TimeoutCycles = 40 * PlannedXfers + 200;

	typedef struct packed {
		logic            write;
		bridgePkg::selT  sel;
		bridgePkg::addrT addr;
		bridgePkg::dataT data;
	} xferT;

	logic              Hclk = 1'b0;
	logic              Hresetn;
	bridgePkg::addrT   Haddr;
	bridgePkg::dataT   Hwdata;
	logic              Hwrite;
	bridgePkg::htransT Htrans;
	logic              Hreadyin;
	bridgePkg::dataT   Hrdata;
	logic              Hreadyout;
	logic [1:0]        Hresp;
	logic              Psel0;
	logic              Psel1;
	logic              Psel2;
	logic              Penable;
	logic              Pwrite;
	bridgePkg::addrT   Paddr;
	bridgePkg::dataT   Pwdata;
	bridgePkg::dataT   Prdata0;
	bridgePkg::dataT   Prdata1;
	bridgePkg::dataT   Prdata2;

	xferT              expXfer [PlannedXfers];
	xferT              headXfer;
	int                expCount = 0;
	int                apbIdx = 0;
	int                errorCount = 0;
	bridgePkg::dataT   readExp;
	bridgePkg::dataT   refMem [192];  // slot = peripheral * 64 + word
	int                slotList [NumBurst];
	logic [15:0]       lfsr;
	logic              anySel;

	ahbApbBridge #(
		.PeriphBase (PeriphBase),
		.RegionShift(RegionShift)
	) ahbApbBridge_inst (.*);

	apbPeripheralModel periph0 (.Hclk, .Hresetn, .Psel(Psel0), .Penable, .Pwrite, .Paddr,
		.Pwdata, .Prdata(Prdata0));
	apbPeripheralModel periph1 (.Hclk, .Hresetn, .Psel(Psel1), .Penable, .Pwrite, .Paddr,
		.Pwdata, .Prdata(Prdata1));
	apbPeripheralModel periph2 (.Hclk, .Hresetn, .Psel(Psel2), .Penable, .Pwrite, .Paddr,
		.Pwdata, .Prdata(Prdata2));

	assign Hreadyin = Hreadyout;  // single slave on the bus
	assign anySel = Psel0 || Psel1 || Psel2;
	assign headXfer = expXfer[apbIdx];

	always #10 Hclk = ~Hclk;

	// an APB transfer retires at the end of its enable cycle
	always @(posedge Hclk)
	begin
		if (Penable)
		begin
			apbIdx <= apbIdx + 1;
			readExp <= headXfer.data;
		end
	end

	function automatic void logMismatch(input string msg);
		errorCount++;
		$display("MISMATCH at %0t ns: %s", $time, msg);
	endfunction

	// fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] takeBits(input int n);
		logic [15:0] val;
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			val = {val[14:0], lfsr[0]};
		end
		return val;
	endfunction

	function automatic int randomSlot();
		int periph;
		periph = int'(takeBits(2)) % 3;
		return periph * 64 + int'(takeBits(6));
	endfunction

	function automatic bridgePkg::addrT slotAddr(input int slot);
		return PeriphBase + ((slot / 64) << RegionShift) + ((slot % 64) << 2);
	endfunction

	task automatic expectXfer(input logic write, input int slot);
		expXfer[expCount] = '{write: write, sel: 3'b001 << (slot / 64), addr: slotAddr(slot),
			data: refMem[slot]};
		expCount++;
	endtask

	// one AHB phase held until an edge with Hreadyout high takes it
	task automatic busPhase(input bridgePkg::htransT trans, input bridgePkg::addrT addr,
		input logic write, input bridgePkg::dataT wdata);
		logic ready;
		Htrans = trans;
		Haddr = addr;
		Hwrite = write;
		Hwdata = wdata;
		do
		begin
			ready = Hreadyout;
			@(negedge Hclk);
		end
		while (!ready);
	endtask

	task automatic drainApb();
		wait (apbIdx == expCount);
		@(negedge Hclk);
	endtask

	// write data rides along with the next address phase
	task automatic writeBurst(input int count);
		bridgePkg::dataT data;
		bridgePkg::dataT prevData;
		prevData = '0;
		for (int i = 0; i < count; i++)
		begin
			slotList[i] = randomSlot();
			data = {takeBits(16), takeBits(16)};
			refMem[slotList[i]] = data;
			expectXfer(1'b1, slotList[i]);
			busPhase(i == 0 ? bridgePkg::transNonseq : bridgePkg::transSeq,
				slotAddr(slotList[i]), 1'b1, prevData);
			prevData = data;
		end
		busPhase(bridgePkg::transIdle, '0, 1'b0, prevData);
		drainApb();
	endtask

	task automatic readSlot(input int slot);
		expectXfer(1'b0, slot);
		busPhase(bridgePkg::transNonseq, slotAddr(slot), 1'b0, '0);
		busPhase(bridgePkg::transIdle, '0, 1'b0, '0);
		drainApb();
	endtask

	task automatic blockedPhases();
		busPhase(bridgePkg::transNonseq, PeriphBase - 4, 1'b1, '0);
		busPhase(bridgePkg::transNonseq, PeriphBase + (3 << RegionShift), 1'b0, '0);
		busPhase(bridgePkg::transIdle, slotAddr(5), 1'b1, '0);
		busPhase(bridgePkg::transBusy, slotAddr(70), 1'b0, '0);
		busPhase(bridgePkg::transIdle, '0, 1'b0, '0);
		repeat (4) @(negedge Hclk);
	endtask

	resetOutputs: assert property (@(posedge Hclk) $past(!Hresetn) |->
		!anySel && !Penable && !Hreadyout)
		else logMismatch("select, Penable or Hreadyout high in or right after reset");

	readyAfterReset: assert property (@(posedge Hclk) $rose(Hresetn) |=> Hreadyout)
		else logMismatch("Hreadyout still low on the second cycle after reset");

	respOkay: assert property (@(posedge Hclk) Hresp == 2'b00)
		else logMismatch("Hresp is not OKAY");

	setupThenEnable: assert property (@(posedge Hclk) disable iff (!Hresetn)
		anySel && !Penable |=> Penable && $stable({Psel2, Psel1, Psel0, Pwrite, Paddr, Pwdata}))
		else logMismatch("APB enable phase does not repeat its setup phase");

	enableOneCycle: assert property (@(posedge Hclk) disable iff (!Hresetn)
		Penable |=> !Penable)
		else logMismatch("Penable high for more than one cycle");

	selectExpected: assert property (@(posedge Hclk) disable iff (!Hresetn)
		anySel |-> apbIdx < expCount)
		else logMismatch("APB select with no eligible AHB transfer pending");

	enableMatches: assert property (@(posedge Hclk) disable iff (!Hresetn)
		Penable |-> {Psel2, Psel1, Psel0} == headXfer.sel && Paddr == headXfer.addr
		&& Pwrite == headXfer.write && (!Pwrite || Pwdata == headXfer.data))
		else logMismatch("APB transfer differs from the expected AHB transfer");

	readReturns: assert property (@(posedge Hclk) disable iff (!Hresetn)
		$past(Penable && !Pwrite) |-> Hreadyout && Hrdata == readExp)
		else logMismatch("Hrdata differs from the reference memory");

	initial
	begin
		Hresetn = 1'b0;
		Haddr = '0;
		Hwdata = '0;
		Hwrite = 1'b0;
		Htrans = bridgePkg::transIdle;
		lfsr = 16'd47;
		for (int i = 0; i < 192; i++)
			refMem[i] = '0;
		repeat (4) @(negedge Hclk);
		Hresetn = 1'b1;
		for (int i = 0; i < NumSingle; i++)
		begin
			writeBurst(1);
			readSlot(slotList[0]);
		end
		for (int i = 0; i < NumBlind; i++)
			readSlot(randomSlot());
		writeBurst(NumBurst);
		for (int i = 0; i < NumBurst; i++)
			readSlot(slotList[i]);
		blockedPhases();
		$display("errors: %0d, APB transfers completed: %0d of %0d", errorCount, apbIdx,
			PlannedXfers);
		if (errorCount == 0 && apbIdx == PlannedXfers)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	initial
	begin
		#(TimeoutCycles * 20);
		$display("timeout: no progress after %0d cycles, bridge or master is stuck",
			TimeoutCycles);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- verification/apbPeripheralModel.sv
// ====================================================================
// APB peripheral model: 64-word memory cleared on reset,
// writes on the enable phase, registered read data
// ====================================================================

module apbPeripheralModel (
	input  logic            Hclk,
	input  logic            Hresetn,
	input  logic            Psel,
	input  logic            Penable,
	input  logic            Pwrite,
	input  bridgePkg::addrT Paddr,
	input  bridgePkg::dataT Pwdata,
	output bridgePkg::dataT Prdata
);

	timeunit 1ns;
	timeprecision 100ps;

	bridgePkg::dataT mem [64];

	always_ff @(posedge Hclk)
	begin
		if (!Hresetn)
		begin
			for (int i = 0; i < 64; i++)
				mem[i] <= '0;
			Prdata <= '0;
		end
		else if (Psel && Penable && Pwrite)
			mem[Paddr[7:2]] <= Pwdata;
		else if (Psel && !Penable && !Pwrite)
			Prdata <= mem[Paddr[7:2]];  // valid through the enable cycle
	end

endmodule
